// ==== verilog/tcp_mem_macros.svh ====
`ifndef TCP_MEM_MACROS_SVH
`define TCP_MEM_MACROS_SVH

// engine side stream width
`define TCP_MEM_NARROW_W 64
// memory side stream width
`define TCP_MEM_WIDE_W 512
// narrow beats packed into one wide beat
`define TCP_MEM_LANES 8

// packed engine command
`define TCP_MEM_CMD_W 72
`define TCP_MEM_CMD_ADDR_LSB 32 // address is bits 63..32
`define TCP_MEM_CMD_LEN_W 23    // length is bits 22..0

// debug counters
`define TCP_MEM_COUNT_W 16

`endif

// ==== verilog/tcp_mem_pkg.sv ====
`include "tcp_mem_macros.svh"

package tcp_mem_pkg;

  // engine command as emitted, still packed
  typedef logic [`TCP_MEM_CMD_W-1:0] cmd_word_t;

  // unpacked memory command fields
  typedef logic [63:0] mem_addr_t;  // zero-extended address
  typedef logic [31:0] mem_len_t;   // zero-extended byte length

  // engine side beat
  typedef logic [`TCP_MEM_NARROW_W-1:0]   narrow_data_t;
  typedef logic [`TCP_MEM_NARROW_W/8-1:0] narrow_keep_t;

  // memory side beat
  typedef logic [`TCP_MEM_WIDE_W-1:0]   wide_data_t;
  typedef logic [`TCP_MEM_WIDE_W/8-1:0] wide_keep_t;

  typedef logic [`TCP_MEM_COUNT_W-1:0] count_t;

  // one-entry command slice
  typedef enum logic {
    SLICE_EMPTY,
    SLICE_FULL
  } slice_state_e;

  // wide-to-narrow splitter
  typedef enum logic {
    SPLIT_IDLE, // waiting for a wide beat
    SPLIT_SEND  // walking lanes of the held beat
  } split_state_e;

endpackage

// ==== verilog/tcp_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// valid/ready stream with keep and last
interface axis_if #(
  parameter int WIDTH = 64
);
  logic               valid;
  logic               ready;
  logic [WIDTH-1:0]   data;
  logic [WIDTH/8-1:0] keep;  // one bit per byte
  logic               last;  // end of packet

  modport src (
    output valid, data, keep, last,
    input  ready
  );
  modport dst (
    input  valid, data, keep, last,
    output ready
  );
  modport mon (
    input valid, ready, data, keep, last
  );
endinterface

// unpacked memory read or write command
interface mem_cmd_if #(
  parameter int ADDR_W = 64,
  parameter int LEN_W  = 32
);
  logic              valid;
  logic              ready;
  logic [ADDR_W-1:0] address;
  logic [LEN_W-1:0]  length;   // bytes

  modport src (
    output valid, address, length,
    input  ready
  );
  modport dst (
    input  valid, address, length,
    output ready
  );
  modport mon (
    input valid, ready, address, length
  );
endinterface

`default_nettype wire

// ==== verilog/mem_cmd_slice.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tcp_mem_macros.svh"

module mem_cmd_slice (
  input  logic                  net_clk,
  input  logic                  net_aresetn,
  input  logic                  cmd_valid,  // packed command from engine
  output logic                  cmd_ready,
  input  tcp_mem_pkg::cmd_word_t cmd_data,
  mem_cmd_if.src                mem_cmd     // unpacked command to memory
);

  tcp_mem_pkg::slice_state_e state;
  tcp_mem_pkg::mem_addr_t    addr_q;
  tcp_mem_pkg::mem_len_t     len_q;
  logic                      in_fire;
  logic                      out_fire;

  // free slot, or slot drains this cycle
  assign cmd_ready = (state == tcp_mem_pkg::SLICE_EMPTY) || mem_cmd.ready;
  assign in_fire   = cmd_valid && cmd_ready;
  assign out_fire  = mem_cmd.valid && mem_cmd.ready;

  assign mem_cmd.valid   = (state == tcp_mem_pkg::SLICE_FULL);
  assign mem_cmd.address = addr_q;
  assign mem_cmd.length  = len_q;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      state <= tcp_mem_pkg::SLICE_EMPTY;
    end else if (in_fire) begin
      state <= tcp_mem_pkg::SLICE_FULL;  // load or reload behind a drain
    end else if (out_fire) begin
      state <= tcp_mem_pkg::SLICE_EMPTY;
    end
  end

  // field extraction, upper bits zero
  always_ff @(posedge net_clk) begin
    if (in_fire) begin
      addr_q <= tcp_mem_pkg::mem_addr_t'(cmd_data[63:`TCP_MEM_CMD_ADDR_LSB]);  // bits 63..32
      len_q  <= tcp_mem_pkg::mem_len_t'(cmd_data[`TCP_MEM_CMD_LEN_W-1:0]);     // bits 22..0
    end
  end

endmodule

`default_nettype wire

// ==== verilog/axis_upsizer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tcp_mem_macros.svh"

module axis_upsizer (
  input  logic net_clk,
  input  logic net_aresetn,
  axis_if.dst  narrow,  // 64-bit beats from engine
  axis_if.src  wide     // 512-bit beats toward memory
);

  localparam int LANE_W = $clog2(`TCP_MEM_LANES);
  localparam int NW     = `TCP_MEM_NARROW_W;
  localparam int NK     = `TCP_MEM_NARROW_W / 8;

  logic [LANE_W-1:0]       lane;       // next lane to fill
  tcp_mem_pkg::wide_data_t acc_data;   // partially filled beat
  tcp_mem_pkg::wide_keep_t acc_keep;
  tcp_mem_pkg::wide_data_t fill_data;  // acc plus incoming lane
  tcp_mem_pkg::wide_keep_t fill_keep;
  tcp_mem_pkg::wide_data_t out_data;   // closed beat waiting on memory
  tcp_mem_pkg::wide_keep_t out_keep;
  logic                    out_last;
  logic                    out_valid;
  logic                    in_fire;
  logic                    close_beat;

  assign narrow.ready = !out_valid || wide.ready;  // pending beat gone or going
  assign in_fire      = narrow.valid && narrow.ready;
  assign close_beat   = (lane == LANE_W'(`TCP_MEM_LANES - 1)) || narrow.last;

  assign wide.valid = out_valid;
  assign wide.data  = out_data;
  assign wide.keep  = out_keep;
  assign wide.last  = out_last;

  // lane 0 starts a clean beat, so unfilled lanes stay zero
  always_comb begin
    fill_data = (lane == '0) ? '0 : acc_data;
    fill_keep = (lane == '0) ? '0 : acc_keep;
    fill_data[lane*NW +: NW] = narrow.data;
    fill_keep[lane*NK +: NK] = narrow.keep;
  end

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      lane      <= '0;
      out_valid <= 1'b0;
    end else if (in_fire && close_beat) begin
      lane      <= '0;    // next packet or next wide beat
      out_valid <= 1'b1;
    end else begin
      if (in_fire) begin
        lane <= lane + 1'b1;
      end
      if (wide.ready) begin
        out_valid <= 1'b0;  // drained
      end
    end
  end

  always_ff @(posedge net_clk) begin
    if (in_fire && close_beat) begin
      out_data <= fill_data;
      out_keep <= fill_keep;
      out_last <= narrow.last;  // last of the closing narrow beat
    end else if (in_fire) begin
      acc_data <= fill_data;
      acc_keep <= fill_keep;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/axis_downsizer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tcp_mem_macros.svh"

module axis_downsizer (
  input  logic net_clk,
  input  logic net_aresetn,
  axis_if.dst  wide,    // 512-bit beats from memory
  axis_if.src  narrow   // 64-bit beats toward engine
);

  localparam int LANE_W = $clog2(`TCP_MEM_LANES);
  localparam int NW     = `TCP_MEM_NARROW_W;
  localparam int NK     = `TCP_MEM_NARROW_W / 8;

  tcp_mem_pkg::split_state_e state;
  logic [LANE_W-1:0]         lane;        // lane on the output now
  logic [LANE_W-1:0]         final_lane;  // highest lane with kept bytes
  tcp_mem_pkg::wide_data_t   hold_data;
  tcp_mem_pkg::wide_keep_t   hold_keep;
  logic                      hold_last;
  logic                      at_final;
  logic                      out_fire;

  assign wide.ready = (state == tcp_mem_pkg::SPLIT_IDLE);  // one wide beat at a time

  assign narrow.valid = (state == tcp_mem_pkg::SPLIT_SEND);
  assign narrow.data  = hold_data[lane*NW +: NW];
  assign narrow.keep  = hold_keep[lane*NK +: NK];
  assign at_final     = (lane == final_lane);
  assign narrow.last  = hold_last && at_final;  // only closing beat of a last wide beat
  assign out_fire     = narrow.valid && narrow.ready;

  // keep is contiguous from byte 0, top occupied lane ends the beat
  always_comb begin
    final_lane = '0;
    for (int l = 0; l < `TCP_MEM_LANES; l++) begin
      if (|hold_keep[l*NK +: NK]) begin
        final_lane = LANE_W'(l);
      end
    end
  end

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      state <= tcp_mem_pkg::SPLIT_IDLE;
      lane  <= '0;
    end else begin
      case (state)
        tcp_mem_pkg::SPLIT_IDLE: begin
          if (wide.valid) begin
            state <= tcp_mem_pkg::SPLIT_SEND;
            lane  <= '0;  // start from lowest lane
          end
        end
        tcp_mem_pkg::SPLIT_SEND: begin
          if (out_fire && at_final) begin
            state <= tcp_mem_pkg::SPLIT_IDLE;
          end else if (out_fire) begin
            lane <= lane + 1'b1;
          end
        end
        default: state <= tcp_mem_pkg::SPLIT_IDLE;
      endcase
    end
  end

  always_ff @(posedge net_clk) begin
    if (wide.valid && wide.ready) begin
      hold_data <= wide.data;
      hold_keep <= wide.keep;
      hold_last <= wide.last;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/transfer_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module transfer_counter (
  input  logic                net_clk,
  input  logic                net_aresetn,
  mem_cmd_if.mon              rd_cmd,          // memory read command, post slice
  axis_if.mon                 rd_data,         // wide read data from memory
  output tcp_mem_pkg::count_t read_cmd_count,
  output tcp_mem_pkg::count_t read_pkg_count
);

  logic cmd_fire;
  logic pkg_fire;

  assign cmd_fire = rd_cmd.valid && rd_cmd.ready;
  assign pkg_fire = rd_data.valid && rd_data.ready && rd_data.last;  // packet end only

  // both wrap naturally at 16 bits
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      read_cmd_count <= '0;
      read_pkg_count <= '0;
    end else begin
      if (cmd_fire) begin
        read_cmd_count <= read_cmd_count + 1'b1;
      end
      if (pkg_fire) begin
        read_pkg_count <= read_pkg_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tcp_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tcp_mem_macros.svh"

module tcp_mem_port (
  input  logic                        net_clk,
  input  logic                        net_aresetn,
  // engine read command, packed
  input  logic                        rd_cmd_valid,
  output logic                        rd_cmd_ready,
  input  tcp_mem_pkg::cmd_word_t      rd_cmd_data,
  // engine write command, packed
  input  logic                        wr_cmd_valid,
  output logic                        wr_cmd_ready,
  input  tcp_mem_pkg::cmd_word_t      wr_cmd_data,
  // memory read command
  output logic                        mem_rd_cmd_valid,
  input  logic                        mem_rd_cmd_ready,
  output tcp_mem_pkg::mem_addr_t      mem_rd_cmd_address,
  output tcp_mem_pkg::mem_len_t       mem_rd_cmd_length,
  // memory write command
  output logic                        mem_wr_cmd_valid,
  input  logic                        mem_wr_cmd_ready,
  output tcp_mem_pkg::mem_addr_t      mem_wr_cmd_address,
  output tcp_mem_pkg::mem_len_t       mem_wr_cmd_length,
  // engine write data, narrow
  input  logic                        wr_data_valid,
  output logic                        wr_data_ready,
  input  tcp_mem_pkg::narrow_data_t   wr_data_data,
  input  tcp_mem_pkg::narrow_keep_t   wr_data_keep,
  input  logic                        wr_data_last,
  // memory write data, wide
  output logic                        mem_wr_data_valid,
  input  logic                        mem_wr_data_ready,
  output tcp_mem_pkg::wide_data_t     mem_wr_data_data,
  output tcp_mem_pkg::wide_keep_t     mem_wr_data_keep,
  output logic                        mem_wr_data_last,
  // memory read data, wide
  input  logic                        mem_rd_data_valid,
  output logic                        mem_rd_data_ready,
  input  tcp_mem_pkg::wide_data_t     mem_rd_data_data,
  input  tcp_mem_pkg::wide_keep_t     mem_rd_data_keep,
  input  logic                        mem_rd_data_last,
  // engine read data, narrow
  output logic                        rd_data_valid,
  input  logic                        rd_data_ready,
  output tcp_mem_pkg::narrow_data_t   rd_data_data,
  output tcp_mem_pkg::narrow_keep_t   rd_data_keep,
  output logic                        rd_data_last,
  // debug
  output tcp_mem_pkg::count_t         read_cmd_count,
  output tcp_mem_pkg::count_t         read_pkg_count
);

  axis_if #(.WIDTH(`TCP_MEM_NARROW_W)) wr_narrow ();  // engine -> upsizer
  axis_if #(.WIDTH(`TCP_MEM_WIDE_W))   wr_wide ();    // upsizer -> memory
  axis_if #(.WIDTH(`TCP_MEM_WIDE_W))   rd_wide ();    // memory -> downsizer
  axis_if #(.WIDTH(`TCP_MEM_NARROW_W)) rd_narrow ();  // downsizer -> engine
  mem_cmd_if                           rd_mem_cmd ();
  mem_cmd_if                           wr_mem_cmd ();

  // command chain
  mem_cmd_slice rd_cmd_slice (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .cmd_valid   (rd_cmd_valid),
    .cmd_ready   (rd_cmd_ready),
    .cmd_data    (rd_cmd_data),
    .mem_cmd     (rd_mem_cmd.src)
  );
  mem_cmd_slice wr_cmd_slice (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .cmd_valid   (wr_cmd_valid),
    .cmd_ready   (wr_cmd_ready),
    .cmd_data    (wr_cmd_data),
    .mem_cmd     (wr_mem_cmd.src)
  );

  assign mem_rd_cmd_valid   = rd_mem_cmd.valid;
  assign rd_mem_cmd.ready   = mem_rd_cmd_ready;
  assign mem_rd_cmd_address = rd_mem_cmd.address;
  assign mem_rd_cmd_length  = rd_mem_cmd.length;
  assign mem_wr_cmd_valid   = wr_mem_cmd.valid;
  assign wr_mem_cmd.ready   = mem_wr_cmd_ready;
  assign mem_wr_cmd_address = wr_mem_cmd.address;
  assign mem_wr_cmd_length  = wr_mem_cmd.length;

  // write data chain
  assign wr_narrow.valid = wr_data_valid;
  assign wr_data_ready   = wr_narrow.ready;
  assign wr_narrow.data  = wr_data_data;
  assign wr_narrow.keep  = wr_data_keep;
  assign wr_narrow.last  = wr_data_last;

  axis_upsizer wr_upsizer (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .narrow      (wr_narrow.dst),
    .wide        (wr_wide.src)
  );

  assign mem_wr_data_valid = wr_wide.valid;
  assign wr_wide.ready     = mem_wr_data_ready;
  assign mem_wr_data_data  = wr_wide.data;
  assign mem_wr_data_keep  = wr_wide.keep;
  assign mem_wr_data_last  = wr_wide.last;

  // read data chain
  assign rd_wide.valid     = mem_rd_data_valid;
  assign mem_rd_data_ready = rd_wide.ready;
  assign rd_wide.data      = mem_rd_data_data;
  assign rd_wide.keep      = mem_rd_data_keep;
  assign rd_wide.last      = mem_rd_data_last;

  axis_downsizer rd_downsizer (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .wide        (rd_wide.dst),
    .narrow      (rd_narrow.src)
  );

  assign rd_data_valid   = rd_narrow.valid;
  assign rd_narrow.ready = rd_data_ready;
  assign rd_data_data    = rd_narrow.data;
  assign rd_data_keep    = rd_narrow.keep;
  assign rd_data_last    = rd_narrow.last;

  // watches the read side of both chains
  transfer_counter rd_counter (
    .net_clk        (net_clk),
    .net_aresetn    (net_aresetn),
    .rd_cmd         (rd_mem_cmd.mon),
    .rd_data        (rd_wide.mon),
    .read_cmd_count (read_cmd_count),
    .read_pkg_count (read_pkg_count)
  );

endmodule

`default_nettype wire

// ==== bench/tcp_mem_port_properties.sv ====
`timescale 1ns/1ps

module tcp_mem_port_properties (
  input logic                      net_clk,
  input logic                      net_aresetn,
  input logic                      mem_rd_cmd_valid,
  input logic                      mem_rd_cmd_ready,
  input tcp_mem_pkg::mem_addr_t    mem_rd_cmd_address,
  input tcp_mem_pkg::mem_len_t     mem_rd_cmd_length,
  input logic                      mem_wr_cmd_valid,
  input logic                      mem_wr_cmd_ready,
  input tcp_mem_pkg::mem_addr_t    mem_wr_cmd_address,
  input tcp_mem_pkg::mem_len_t     mem_wr_cmd_length,
  input logic                      mem_wr_data_valid,
  input logic                      mem_wr_data_ready,
  input tcp_mem_pkg::wide_data_t   mem_wr_data_data,
  input logic                      mem_wr_data_last,
  input logic                      rd_data_valid,
  input logic                      rd_data_ready,
  input tcp_mem_pkg::narrow_data_t rd_data_data,
  input logic                      rd_data_last,
  input tcp_mem_pkg::count_t       read_cmd_count,
  input tcp_mem_pkg::count_t       read_pkg_count
);

  int assert_failures = 0;  // seen by the testbench at end of run

  reset_clears_valid: assert property (@(posedge net_clk)
    !net_aresetn |=> !(mem_rd_cmd_valid || mem_wr_cmd_valid || mem_wr_data_valid || rd_data_valid))
    else begin
      $error("output valid high in the cycle after reset");
      assert_failures++;
    end

  // stalled beats and commands must not move
  rd_cmd_held: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    mem_rd_cmd_valid && !mem_rd_cmd_ready |=>
      mem_rd_cmd_valid && $stable(mem_rd_cmd_address) && $stable(mem_rd_cmd_length))
    else begin
      $error("memory read command changed while stalled");
      assert_failures++;
    end

  wr_cmd_held: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    mem_wr_cmd_valid && !mem_wr_cmd_ready |=>
      mem_wr_cmd_valid && $stable(mem_wr_cmd_address) && $stable(mem_wr_cmd_length))
    else begin
      $error("memory write command changed while stalled");
      assert_failures++;
    end

  wr_data_held: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    mem_wr_data_valid && !mem_wr_data_ready |=>
      mem_wr_data_valid && $stable(mem_wr_data_data) && $stable(mem_wr_data_last))
    else begin
      $error("wide write beat changed while stalled");
      assert_failures++;
    end

  rd_data_held: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    rd_data_valid && !rd_data_ready |=> rd_data_valid && $stable(rd_data_data) && $stable(rd_data_last))
    else begin
      $error("narrow read beat changed while stalled");
      assert_failures++;
    end

  // step of one, or hold; the +1 wraps at 16 bits
  counters_monotonic: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    (read_cmd_count == $past(read_cmd_count) ||
     read_cmd_count == tcp_mem_pkg::count_t'($past(read_cmd_count) + 1'b1)) &&
    (read_pkg_count == $past(read_pkg_count) ||
     read_pkg_count == tcp_mem_pkg::count_t'($past(read_pkg_count) + 1'b1)))
    else begin
      $error("debug counter moved backwards");
      assert_failures++;
    end

endmodule

bind tcp_mem_port tcp_mem_port_properties props0 (.*);

// ==== bench/tcp_mem_port_tb.sv ====
`timescale 1ns/1ps

module tcp_mem_port_tb;

  typedef struct packed {
    tcp_mem_pkg::narrow_data_t data;
    tcp_mem_pkg::narrow_keep_t keep;
    logic                      last;
  } narrow_beat_t;
  typedef struct packed {
    tcp_mem_pkg::wide_data_t data;
    tcp_mem_pkg::wide_keep_t keep;
    logic                    last;
  } wide_beat_t;
  typedef struct packed {
    tcp_mem_pkg::mem_addr_t addr;
    tcp_mem_pkg::mem_len_t  len;
  } mem_cmd_t;

  logic                      net_clk;
  logic                      net_aresetn;
  logic                      rd_cmd_valid;
  logic                      rd_cmd_ready;
  tcp_mem_pkg::cmd_word_t    rd_cmd_data;
  logic                      wr_cmd_valid;
  logic                      wr_cmd_ready;
  tcp_mem_pkg::cmd_word_t    wr_cmd_data;
  logic                      mem_rd_cmd_valid;
  logic                      mem_rd_cmd_ready;
  tcp_mem_pkg::mem_addr_t    mem_rd_cmd_address;
  tcp_mem_pkg::mem_len_t     mem_rd_cmd_length;
  logic                      mem_wr_cmd_valid;
  logic                      mem_wr_cmd_ready;
  tcp_mem_pkg::mem_addr_t    mem_wr_cmd_address;
  tcp_mem_pkg::mem_len_t     mem_wr_cmd_length;
  logic                      wr_data_valid;
  logic                      wr_data_ready;
  tcp_mem_pkg::narrow_data_t wr_data_data;
  tcp_mem_pkg::narrow_keep_t wr_data_keep;
  logic                      wr_data_last;
  logic                      mem_wr_data_valid;
  logic                      mem_wr_data_ready;
  tcp_mem_pkg::wide_data_t   mem_wr_data_data;
  tcp_mem_pkg::wide_keep_t   mem_wr_data_keep;
  logic                      mem_wr_data_last;
  logic                      mem_rd_data_valid;
  logic                      mem_rd_data_ready;
  tcp_mem_pkg::wide_data_t   mem_rd_data_data;
  tcp_mem_pkg::wide_keep_t   mem_rd_data_keep;
  logic                      mem_rd_data_last;
  logic                      rd_data_valid;
  logic                      rd_data_ready;
  tcp_mem_pkg::narrow_data_t rd_data_data;
  tcp_mem_pkg::narrow_keep_t rd_data_keep;
  logic                      rd_data_last;
  tcp_mem_pkg::count_t       read_cmd_count;
  tcp_mem_pkg::count_t       read_pkg_count;

  tcp_mem_pkg::cmd_word_t rdcmd_q[$];    // pending engine commands
  tcp_mem_pkg::cmd_word_t wrcmd_q[$];
  narrow_beat_t           wr_q[$];       // pending engine write beats
  wide_beat_t             rdw_q[$];      // pending memory read beats
  mem_cmd_t               exp_rd_cmd[$];
  mem_cmd_t               exp_wr_cmd[$];
  mem_cmd_t               got_rd_cmd[$];
  mem_cmd_t               got_wr_cmd[$];
  wide_beat_t             exp_wide[$];
  wide_beat_t             got_wide[$];
  narrow_beat_t           exp_narrow[$];
  narrow_beat_t           got_narrow[$];
  logic [15:0]            lfsr_state;
  logic                   stall_en;        // random readys on the data outputs
  logic                   rd_cmd_rdy_lvl;  // memory read command ready
  int                     rd_cmd_total;    // read commands queued, each reaches memory
  int                     rd_pkg_total;    // wide read beats queued with last

  tcp_mem_port dut0 (.*);

  initial begin
    net_clk = 1'b0;
    forever #20 net_clk = ~net_clk;  // 40 ns period
  end

  // galois form, taps 16,14,13,11
  function automatic logic next_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b)
      lfsr_state = lfsr_state ^ 16'hB400;
    return b;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[62:0], next_bit()};  // one step per bit
    return v;
  endfunction

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_value(input string name, input logic [511:0] got,
                             input logic [511:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // queue heads go on the pins, readys from level or lfsr
  task automatic drive_inputs();
    rd_cmd_valid = (rdcmd_q.size() != 0);
    rd_cmd_data  = rd_cmd_valid ? rdcmd_q[0] : '0;
    wr_cmd_valid = (wrcmd_q.size() != 0);
    wr_cmd_data  = wr_cmd_valid ? wrcmd_q[0] : '0;
    wr_data_valid = (wr_q.size() != 0);
    {wr_data_data, wr_data_keep, wr_data_last} = wr_data_valid ? wr_q[0] : '0;
    mem_rd_data_valid = (rdw_q.size() != 0);
    {mem_rd_data_data, mem_rd_data_keep, mem_rd_data_last} = mem_rd_data_valid ? rdw_q[0] : '0;
    mem_rd_cmd_ready  = rd_cmd_rdy_lvl;
    mem_wr_cmd_ready  = 1'b1;
    mem_wr_data_ready = stall_en ? next_bit() : 1'b1;
    rd_data_ready     = stall_en ? next_bit() : 1'b1;
  endtask

  // one clock: log handshakes at negedge, drive 2 ns after the edge
  task automatic tick();
    @(negedge net_clk);
    if (mem_rd_cmd_valid && mem_rd_cmd_ready)
      got_rd_cmd.push_back({mem_rd_cmd_address, mem_rd_cmd_length});
    if (mem_wr_cmd_valid && mem_wr_cmd_ready)
      got_wr_cmd.push_back({mem_wr_cmd_address, mem_wr_cmd_length});
    if (mem_wr_data_valid && mem_wr_data_ready)
      got_wide.push_back({mem_wr_data_data, mem_wr_data_keep, mem_wr_data_last});
    if (rd_data_valid && rd_data_ready)
      got_narrow.push_back({rd_data_data, rd_data_keep, rd_data_last});
    if (rd_cmd_valid && rd_cmd_ready)
      void'(rdcmd_q.pop_front());  // taken at the coming edge
    if (wr_cmd_valid && wr_cmd_ready)
      void'(wrcmd_q.pop_front());
    if (wr_data_valid && wr_data_ready)
      void'(wr_q.pop_front());
    if (mem_rd_data_valid && mem_rd_data_ready)
      void'(rdw_q.pop_front());
    @(posedge net_clk);
    #2;
    drive_inputs();
  endtask

  task automatic settle();
    #10;  // mid-cycle, combinational outputs stable
  endtask

  function automatic logic traffic_done();
    return rdcmd_q.size() == 0 && wrcmd_q.size() == 0 && wr_q.size() == 0 &&
           rdw_q.size() == 0 && got_rd_cmd.size() >= exp_rd_cmd.size() &&
           got_wr_cmd.size() >= exp_wr_cmd.size() && got_wide.size() >= exp_wide.size() &&
           got_narrow.size() >= exp_narrow.size();
  endfunction

  task automatic run_until_done(input int max_cycles, input string what);
    int n;
    n = 0;
    while (!traffic_done()) begin
      if (n == max_cycles)
        fail_with({"timeout while waiting for ", what});
      tick();
      n++;
    end
  endtask

  task automatic queue_cmd(input logic is_read, input tcp_mem_pkg::cmd_word_t cmd);
    mem_cmd_t e;
    e.addr = {32'h0, cmd[63:32]};  // address field, zero-extended
    e.len  = {9'h0, cmd[22:0]};    // length field, zero-extended
    if (is_read) begin
      rdcmd_q.push_back(cmd);
      exp_rd_cmd.push_back(e);
      rd_cmd_total++;
    end else begin
      wrcmd_q.push_back(cmd);
      exp_wr_cmd.push_back(e);
    end
  endtask

  task automatic queue_random_cmd(input logic is_read);
    logic [63:0] hi;
    hi = rand_bits(8);
    queue_cmd(is_read, {hi[7:0], rand_bits(64)});
  endtask

  // beat k lands in lane k mod 8, close on lane 7 or last
  task automatic queue_write_packet(input int nbeats, input logic [7:0] final_keep);
    narrow_beat_t b;
    wide_beat_t   acc;
    int           lane;
    acc  = '0;
    lane = 0;
    for (int k = 0; k < nbeats; k++) begin
      b.data = rand_bits(64);
      b.keep = (k == nbeats - 1) ? final_keep : 8'hFF;
      b.last = (k == nbeats - 1);
      wr_q.push_back(b);
      acc.data[lane*64 +: 64] = b.data;
      acc.keep[lane*8 +: 8]   = b.keep;
      if (lane == 7 || b.last) begin
        acc.last = b.last;
        exp_wide.push_back(acc);
        acc  = '0;  // unfilled lanes stay zero
        lane = 0;
      end else begin
        lane++;
      end
    end
  endtask

  // ceil(kept bytes / 8) narrow beats from lane 0 up
  task automatic queue_read_beat(input int nbytes, input logic last);
    wide_beat_t   w;
    narrow_beat_t n;
    int           beats;
    for (int l = 0; l < 8; l++)
      w.data[l*64 +: 64] = rand_bits(64);
    w.keep = {64{1'b1}} >> (64 - nbytes);  // contiguous from byte 0
    w.last = last;
    rdw_q.push_back(w);
    if (last)
      rd_pkg_total++;
    beats = ($countones(w.keep) + 7) / 8;
    for (int l = 0; l < beats; l++) begin
      n.data = w.data[l*64 +: 64];
      n.keep = w.keep[l*8 +: 8];
      n.last = last && (l == beats - 1);
      exp_narrow.push_back(n);
    end
  endtask

  task automatic compare_outputs();
    check_value("mem_rd_cmd transfers", got_rd_cmd.size(), exp_rd_cmd.size());
    check_value("mem_wr_cmd transfers", got_wr_cmd.size(), exp_wr_cmd.size());
    check_value("mem_wr_data beats", got_wide.size(), exp_wide.size());
    check_value("rd_data beats", got_narrow.size(), exp_narrow.size());
    foreach (exp_rd_cmd[i]) begin
      check_value("mem_rd_cmd_address", got_rd_cmd[i].addr, exp_rd_cmd[i].addr);
      check_value("mem_rd_cmd_length", got_rd_cmd[i].len, exp_rd_cmd[i].len);
    end
    foreach (exp_wr_cmd[i]) begin
      check_value("mem_wr_cmd_address", got_wr_cmd[i].addr, exp_wr_cmd[i].addr);
      check_value("mem_wr_cmd_length", got_wr_cmd[i].len, exp_wr_cmd[i].len);
    end
    foreach (exp_wide[i]) begin
      check_value("mem_wr_data_data", got_wide[i].data, exp_wide[i].data);
      check_value("mem_wr_data_keep", got_wide[i].keep, exp_wide[i].keep);
      check_value("mem_wr_data_last", got_wide[i].last, exp_wide[i].last);
    end
    foreach (exp_narrow[i]) begin
      check_value("rd_data_data", got_narrow[i].data, exp_narrow[i].data);
      check_value("rd_data_keep", got_narrow[i].keep, exp_narrow[i].keep);
      check_value("rd_data_last", got_narrow[i].last, exp_narrow[i].last);
    end
    exp_rd_cmd.delete();
    exp_wr_cmd.delete();
    got_rd_cmd.delete();
    got_wr_cmd.delete();
    exp_wide.delete();
    got_wide.delete();
    exp_narrow.delete();
    got_narrow.delete();
  endtask

  task automatic test_cmd_unpack();
    int n;
    for (int i = 0; i < 4; i++) begin
      queue_random_cmd(1'b1);
      queue_random_cmd(1'b0);
    end
    run_until_done(100, "unpacked commands");
    compare_outputs();
    rd_cmd_rdy_lvl = 1'b0;  // memory refuses reads
    queue_random_cmd(1'b1);
    queue_random_cmd(1'b1);
    n = 0;
    while (!(mem_rd_cmd_valid && rdcmd_q.size() == 1)) begin
      if (n == 20)
        fail_with("timeout waiting for the read command slice to fill");
      tick();
      n++;
    end
    for (int i = 0; i < 3; i++) begin
      settle();
      check_value("rd_cmd_ready", rd_cmd_ready, 0);  // slice full, nothing drains
      check_value("mem_rd_cmd_valid", mem_rd_cmd_valid, 1);
      check_value("mem_rd_cmd_address", mem_rd_cmd_address, exp_rd_cmd[0].addr);
      tick();
    end
    rd_cmd_rdy_lvl = 1'b1;
    run_until_done(50, "held read commands");
    compare_outputs();
  endtask

  task automatic test_full_packet();
    queue_write_packet(16, 8'hFF);
    run_until_done(100, "two wide write beats");
    check_value("mem_wr_data_keep", got_wide[0].keep, {64{1'b1}});
    check_value("mem_wr_data_last", got_wide[0].last, 0);
    check_value("mem_wr_data_last", got_wide[1].last, 1);
    compare_outputs();
  endtask

  task automatic test_short_packet();
    queue_write_packet(3, 8'h0F);
    run_until_done(50, "short wide write beat");
    check_value("mem_wr_data_keep", got_wide[0].keep, 64'h0000_0000_000F_FFFF);
    compare_outputs();
  endtask

  task automatic test_read_split();
    queue_read_beat(20, 1'b1);
    queue_read_beat(64, 1'b0);
    run_until_done(100, "narrow read beats");
    check_value("rd_data_keep", got_narrow[2].keep, 8'h0F);
    check_value("rd_data_last", got_narrow[2].last, 1);
    check_value("rd_data_last", got_narrow[10].last, 0);
    compare_outputs();
  endtask

  task automatic test_random_stalls();
    int len;
    int kb;
    stall_en = 1'b1;
    for (int p = 0; p < 4; p++) begin
      len = 1 + int'(rand_bits(5)) % 20;
      kb  = 1 + int'(rand_bits(3));
      queue_write_packet(len, 8'hFF >> (8 - kb));
    end
    for (int i = 0; i < 6; i++) begin
      kb = 1 + int'(rand_bits(6));
      queue_read_beat(kb, (i == 5) || (rand_bits(1) != 0));
    end
    run_until_done(3000, "traffic under random stalls");
    stall_en = 1'b0;
    compare_outputs();
  endtask

  task automatic test_counters();
    tick();
    tick();
    settle();
    check_value("read_cmd_count", read_cmd_count, rd_cmd_total);
    check_value("read_pkg_count", read_pkg_count, rd_pkg_total);
  endtask

  initial begin
    lfsr_state     = 16'd51582;
    stall_en       = 1'b0;
    rd_cmd_rdy_lvl = 1'b1;
    rd_cmd_total   = 0;
    rd_pkg_total   = 0;
    net_aresetn    = 1'b0;
    drive_inputs();  // idle values on every input
    repeat (5) @(posedge net_clk);
    #2;
    net_aresetn = 1'b1;
    settle();
    check_value("mem_rd_cmd_valid", mem_rd_cmd_valid, 0);
    check_value("mem_wr_cmd_valid", mem_wr_cmd_valid, 0);
    check_value("mem_wr_data_valid", mem_wr_data_valid, 0);
    check_value("rd_data_valid", rd_data_valid, 0);
    check_value("read_cmd_count", read_cmd_count, 0);
    check_value("read_pkg_count", read_pkg_count, 0);
    test_cmd_unpack();
    test_full_packet();
    test_short_packet();
    test_read_split();
    test_random_stalls();
    test_counters();
    if (dut0.props0.assert_failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== tcp_mem_port.f ====
+incdir+verilog
verilog/tcp_mem_pkg.sv
verilog/tcp_mem_if.sv
verilog/mem_cmd_slice.sv
verilog/axis_upsizer.sv
verilog/axis_downsizer.sv
verilog/transfer_counter.sv
verilog/tcp_mem_port.sv
bench/tcp_mem_port_properties.sv
bench/tcp_mem_port_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tcp_mem_port.f \
  --top-module tcp_mem_port_tb -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vtcp_mem_port_tb > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q "^ALL CHECKS PASSED$" sim.log 2> /dev/null && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
